/* axi_link_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_link_bridge
    import axi_pkg::*;
    import link_pkg::*;
(
    input  wire                SLAVE_CLK,
    input  wire                rstn,
    input  wire [ID_W-1:0]     i_awid,
    input  wire [ADDR_W-1:0]   i_awaddr,
    input  wire [LEN_W-1:0]    i_awlen,
    input  wire                i_awvalid,
    output logic               o_awready,
    input  wire [DATA_W-1:0]   i_wdata,
    input  wire                i_wvalid,
    output logic               o_wready,
    output logic [ID_W-1:0]    o_bid,
    output logic [RESP_W-1:0]  o_bresp,
    output logic               o_bvalid,
    input  wire                i_bready,
    input  wire [ID_W-1:0]     i_arid,
    input  wire [ADDR_W-1:0]   i_araddr,
    input  wire [LEN_W-1:0]    i_arlen,
    input  wire                i_arvalid,
    output logic               o_arready,
    output logic [ID_W-1:0]    o_rid,
    output logic [DATA_W-1:0]  o_rdata,
    output logic [RESP_W-1:0]  o_rresp,
    output logic               o_rlast,
    output logic               o_rvalid,
    input  wire                i_rready,
    input  wire [DATA_W-1:0]   i_rx_data,
    input  wire                i_rx_valid,
    input  wire                i_rx_last,
    output logic [31:0]        o_tx_data,
    output logic [K_W-1:0]     o_tx_k
);

    logic              read_done, trig_set;
    logic              beat_valid, beat_ready;
    logic [DATA_W-1:0] beat_data, fifo_data;
    logic              fifo_wr, fifo_last;

    task_if remote_task ();
    task_if local_task ();

    axi_slave_port axi_slave_port_inst (
        .SLAVE_CLK (SLAVE_CLK), .rstn (rstn),
        .i_awid (i_awid), .i_awaddr (i_awaddr), .i_awlen (i_awlen),
        .i_awvalid (i_awvalid), .o_awready (o_awready),
        .i_wdata (i_wdata), .i_wvalid (i_wvalid), .o_wready (o_wready),
        .o_bid (o_bid), .o_bresp (o_bresp), .o_bvalid (o_bvalid), .i_bready (i_bready),
        .i_arid (i_arid), .i_araddr (i_araddr), .i_arlen (i_arlen),
        .i_arvalid (i_arvalid), .o_arready (o_arready), .o_rid (o_rid),
        .i_read_done (read_done),
        .remote_task (remote_task.issuer), .local_task (local_task.issuer)
    );

    link_tx_framer link_tx_framer_inst (
        .SLAVE_CLK (SLAVE_CLK), .rstn (rstn), .remote_task (remote_task.target),
        .o_tx_data (o_tx_data), .o_tx_k (o_tx_k)
    );

    local_status_unit local_status_unit_inst (
        .SLAVE_CLK (SLAVE_CLK), .rstn (rstn), .local_task (local_task.target),
        .i_trig_set (trig_set), .o_beat_valid (beat_valid),
        .o_beat_data (beat_data), .i_beat_ready (beat_ready)
    );

    link_rx_parser link_rx_parser_inst (
        .SLAVE_CLK (SLAVE_CLK), .rstn (rstn),
        .i_rx_data (i_rx_data), .i_rx_valid (i_rx_valid), .i_rx_last (i_rx_last),
        .o_fifo_wr (fifo_wr), .o_fifo_data (fifo_data), .o_fifo_last (fifo_last),
        .o_trig_set (trig_set)
    );

    rd_return_unit rd_return_unit_inst (
        .SLAVE_CLK (SLAVE_CLK), .rstn (rstn),
        .i_fifo_wr (fifo_wr), .i_fifo_data (fifo_data), .i_fifo_last (fifo_last),
        .i_beat_valid (beat_valid), .i_beat_data (beat_data), .o_beat_ready (beat_ready),
        .o_rdata (o_rdata), .o_rresp (o_rresp), .o_rlast (o_rlast), .o_rvalid (o_rvalid),
        .i_rready (i_rready), .o_read_done (read_done)
    );

endmodule

`default_nettype wire

/* axi_link_bridge_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_link_bridge_sva
    import axi_pkg::*;
    import link_pkg::*;
(
    input wire               SLAVE_CLK,
    input wire               rstn,
    input wire               i_rvalid,
    input wire               i_rready,
    input wire [DATA_W-1:0]  i_rdata,
    input wire               i_bvalid,
    input wire               i_bready,
    input wire [31:0]        i_tx_data,
    input wire [K_W-1:0]     i_tx_k
);

    // stalled R beat keeps its data
    r_hold: assert property (@(posedge SLAVE_CLK) disable iff (!rstn)
        (i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_rdata)))
        else $error("rvalid or rdata changed while rready was low");

    b_hold: assert property (@(posedge SLAVE_CLK) disable iff (!rstn)
        (i_bvalid && !i_bready) |=> i_bvalid)
        else $error("bvalid dropped before bready");

    // k flags mark the idle comma fill only
    k_idle: assert property (@(posedge SLAVE_CLK) disable iff (!rstn)
        (i_tx_k == {K_W{1'b1}}) == (i_tx_data == IDLE_WORD))
        else $error("tx k flags disagree with the idle word");

endmodule

bind axi_link_bridge axi_link_bridge_sva i_axi_link_bridge_sva (
    .SLAVE_CLK (SLAVE_CLK),
    .rstn      (rstn),
    .i_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .i_rdata   (o_rdata),
    .i_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_tx_data (o_tx_data),
    .i_tx_k    (o_tx_k)
);

`default_nettype wire

/* axi_pkg.sv */
`default_nettype none

// bus side widths and address decode
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;
    localparam int RESP_W = 2;

    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    // bit 24 set means the target sits behind the serial link
    localparam int REMOTE_BIT   = 24;
    localparam int LOCAL_ADDR_W = 24;

    localparam logic [LOCAL_ADDR_W-1:0] STATUS_ADDR = 24'h00_0001;

endpackage

`default_nettype wire

/* axi_slave_port.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_slave_port
    import axi_pkg::*;
(
    input  wire                SLAVE_CLK,
    input  wire                rstn,
    input  wire [ID_W-1:0]     i_awid,
    input  wire [ADDR_W-1:0]   i_awaddr,
    input  wire [LEN_W-1:0]    i_awlen,
    input  wire                i_awvalid,
    output logic               o_awready,
    input  wire [DATA_W-1:0]   i_wdata,
    input  wire                i_wvalid,
    output logic               o_wready,
    output logic [ID_W-1:0]    o_bid,
    output logic [RESP_W-1:0]  o_bresp,
    output logic               o_bvalid,
    input  wire                i_bready,
    input  wire [ID_W-1:0]     i_arid,
    input  wire [ADDR_W-1:0]   i_araddr,
    input  wire [LEN_W-1:0]    i_arlen,
    input  wire                i_arvalid,
    output logic               o_arready,
    output logic [ID_W-1:0]    o_rid,
    input  wire                i_read_done,
    task_if.issuer             remote_task,
    task_if.issuer             local_task
);

    logic              aw_hold, w_hold, ar_hold, rd_shown;
    logic [ID_W-1:0]   awid_q, arid_q;
    logic [ADDR_W-1:0] awaddr_q, araddr_q;
    logic [LEN_W-1:0]  awlen_q, arlen_q;
    logic [DATA_W-1:0] wdata_q;
    logic              aw_fire, w_fire, ar_fire;
    logic              wr_pend, wr_remote, rd_remote, same_dst;
    logic              rd_go, wr_go, rd_fire, wr_fire;
    logic              rd_to_remote, rd_to_local;

    assign aw_fire = i_awvalid & o_awready;
    assign w_fire  = i_wvalid & o_wready;
    assign ar_fire = i_arvalid & o_arready;

    // a new write waits until the previous B has been taken
    assign wr_pend   = aw_hold & w_hold & ~o_bvalid;
    assign wr_remote = awaddr_q[REMOTE_BIT];
    assign rd_remote = araddr_q[REMOTE_BIT];
    assign same_dst  = (wr_remote == rd_remote);

    // write wins a shared target unless the read is already on offer
    assign rd_go   = ar_hold & (rd_shown | ~(wr_pend & same_dst));
    assign wr_go   = wr_pend & ~(rd_go & same_dst);
    assign rd_fire = rd_go & (rd_remote ? remote_task.ready : local_task.ready);
    assign wr_fire = wr_go & (wr_remote ? remote_task.ready : local_task.ready);

    assign rd_to_remote = rd_go & rd_remote;
    assign rd_to_local  = rd_go & ~rd_remote;

    assign remote_task.valid   = rd_to_remote | (wr_go & wr_remote);
    assign remote_task.is_read = rd_to_remote;
    assign remote_task.addr    = rd_to_remote ? araddr_q : awaddr_q;
    assign remote_task.len     = rd_to_remote ? arlen_q : awlen_q;
    assign remote_task.data    = wdata_q;

    assign local_task.valid   = rd_to_local | (wr_go & ~wr_remote);
    assign local_task.is_read = rd_to_local;
    assign local_task.addr    = rd_to_local ? araddr_q : awaddr_q;
    assign local_task.len     = rd_to_local ? arlen_q : awlen_q;
    assign local_task.data    = wdata_q;

    assign o_bresp = RESP_OKAY;
    assign o_rid   = arid_q;

    always_ff @(posedge SLAVE_CLK or negedge rstn) begin
        if (!rstn) begin
            o_awready <= 1'b1;
            o_wready  <= 1'b1;
            o_arready <= 1'b1;
            o_bvalid  <= 1'b0;
            aw_hold   <= 1'b0;
            w_hold    <= 1'b0;
            ar_hold   <= 1'b0;
            rd_shown  <= 1'b0;
        end else begin
            if (aw_fire) begin
                o_awready <= 1'b0;
                aw_hold   <= 1'b1;
            end else if (wr_fire) begin
                o_awready <= 1'b1;
                aw_hold   <= 1'b0;
            end
            if (w_fire) begin
                o_wready <= 1'b0;
                w_hold   <= 1'b1;
            end else if (wr_fire) begin
                o_wready <= 1'b1;
                w_hold   <= 1'b0;
            end
            if (wr_fire) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
            // address channel stays closed until the last R beat is taken
            if (ar_fire) begin
                o_arready <= 1'b0;
            end else if (i_read_done) begin
                o_arready <= 1'b1;
            end
            if (ar_fire) begin
                ar_hold <= 1'b1;
            end else if (rd_fire) begin
                ar_hold <= 1'b0;
            end
            rd_shown <= rd_go & ~rd_fire;
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (aw_fire) begin
            awid_q   <= i_awid;
            awaddr_q <= i_awaddr;
            awlen_q  <= i_awlen;
        end
        if (w_fire) begin
            wdata_q <= i_wdata;
        end
        if (ar_fire) begin
            arid_q   <= i_arid;
            araddr_q <= i_araddr;
            arlen_q  <= i_arlen;
        end
        if (wr_fire) begin
            o_bid <= awid_q;
        end
    end

endmodule

`default_nettype wire

/* bridge_trace.txt */
// op a b c d e in hex: 0 idle, 1 write id addr data cmd, 2 read id addr len expect
// 3 rx burst count w0 w1 w2 w3, 4 rx command word, F end; expect is cmd word or local data
0 0 0 0 0 0
1 3 01001234 CAFE5678 12345678 0
0 0 0 0 0 0
2 5 01000040 3 00030040 0
3 4 11111111 22222222 33333333 44444444
0 0 0 0 0 0
4 FFFFFFFF 0 0 0 0
2 6 00000001 0 00000001 0
1 7 00000001 FFFFFFFF 0 0
2 8 00000001 0 00000000 0
2 9 00000010 0 00000000 0
0 0 0 0 0 0
F 0 0 0 0 0

/* link_pkg.sv */
`default_nettype none

// serial link symbols, framing bytes and state encodings
package link_pkg;

    localparam int K_W = 4;

    // comma fill between frames, all bytes are K symbols
    localparam logic [31:0] IDLE_WORD = 32'hBCBC_BCBC;

    localparam logic [7:0] WR_HEAD_BYTE = 8'h00;
    localparam logic [7:0] RD_HEAD_BYTE = 8'hFF;

    // also the clear request when written to the status register
    localparam logic [31:0] TRIG_CMD = 32'hFFFF_FFFF;

    localparam int FIFO_DEPTH = 16;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_RD_HEAD,
        TX_WR_HEAD,
        TX_CMD
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PORT_DATA,
        RX_CMD
    } rx_state_t;

    typedef enum logic {
        LOC_IDLE,
        LOC_RD_BEAT
    } local_state_t;

endpackage

`default_nettype wire

/* link_rx_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module link_rx_parser
    import axi_pkg::*;
    import link_pkg::*;
(
    input  wire                SLAVE_CLK,
    input  wire                rstn,
    input  wire [DATA_W-1:0]   i_rx_data,
    input  wire                i_rx_valid,
    input  wire                i_rx_last,
    output logic               o_fifo_wr,
    output logic [DATA_W-1:0]  o_fifo_data,
    output logic               o_fifo_last,
    output logic               o_trig_set
);

    rx_state_t state;

    // words after a data header go straight into the return FIFO
    assign o_fifo_wr   = (state == RX_PORT_DATA) & i_rx_valid;
    assign o_fifo_data = i_rx_data;
    assign o_fifo_last = i_rx_last;
    assign o_trig_set  = (state == RX_CMD) & i_rx_valid & (i_rx_data == TRIG_CMD);

    always_ff @(posedge SLAVE_CLK or negedge rstn) begin
        if (!rstn) begin
            state <= RX_IDLE;
        end else if (i_rx_valid) begin
            case (state)
                RX_IDLE: begin
                    if (i_rx_data[DATA_W-1 -: 8] == RD_HEAD_BYTE) begin
                        state <= RX_PORT_DATA;
                    end else if (i_rx_data[DATA_W-1 -: 8] == WR_HEAD_BYTE) begin
                        state <= RX_CMD;
                    end
                end
                RX_PORT_DATA: begin
                    if (i_rx_last) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* link_tx_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module link_tx_framer
    import axi_pkg::*;
    import link_pkg::*;
(
    input  wire             SLAVE_CLK,
    input  wire             rstn,
    task_if.target          remote_task,
    output logic [31:0]     o_tx_data,
    output logic [K_W-1:0]  o_tx_k
);

    tx_state_t         state;
    logic [DATA_W-1:0] cmd_q;
    logic              fire;

    assign remote_task.ready = (state == TX_IDLE);
    assign fire              = remote_task.valid & remote_task.ready;

    always_ff @(posedge SLAVE_CLK or negedge rstn) begin
        if (!rstn) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (fire) begin
                        state <= remote_task.is_read ? TX_RD_HEAD : TX_WR_HEAD;
                    end
                end
                TX_RD_HEAD: state <= TX_CMD;
                TX_WR_HEAD: state <= TX_CMD;
                default:    state <= TX_IDLE;
            endcase
        end
    end

    // read: length and low address, write: low address and low data
    always_ff @(posedge SLAVE_CLK) begin
        if (fire) begin
            if (remote_task.is_read) begin
                cmd_q <= {8'h00, remote_task.len, remote_task.addr[15:0]};
            end else begin
                cmd_q <= {remote_task.addr[15:0], remote_task.data[15:0]};
            end
        end
    end

    always_comb begin
        case (state)
            TX_RD_HEAD: o_tx_data = {RD_HEAD_BYTE, 24'h00_0000};
            TX_WR_HEAD: o_tx_data = {WR_HEAD_BYTE, 24'h00_0000};
            TX_CMD:     o_tx_data = cmd_q;
            default:    o_tx_data = IDLE_WORD;
        endcase
        o_tx_k = (state == TX_IDLE) ? {K_W{1'b1}} : {K_W{1'b0}};
    end

endmodule

`default_nettype wire

/* local_status_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module local_status_unit
    import axi_pkg::*;
    import link_pkg::*;
(
    input  wire                SLAVE_CLK,
    input  wire                rstn,
    task_if.target             local_task,
    input  wire                i_trig_set,
    output logic               o_beat_valid,
    output logic [DATA_W-1:0]  o_beat_data,
    input  wire                i_beat_ready
);

    local_state_t      state;
    logic              trig_done;
    logic [DATA_W-1:0] status_word;
    logic              fire, addr_hit, trig_clear;

    assign local_task.ready = (state == LOC_IDLE);
    assign fire             = local_task.valid & local_task.ready;
    assign addr_hit         = (local_task.addr[LOCAL_ADDR_W-1:0] == STATUS_ADDR);
    assign trig_clear       = fire & ~local_task.is_read & addr_hit
                              & (local_task.data == TRIG_CMD);

    // only bit 0 is live, the rest read as zero
    assign status_word  = {{(DATA_W-1){1'b0}}, trig_done};
    assign o_beat_valid = (state == LOC_RD_BEAT);

    always_ff @(posedge SLAVE_CLK or negedge rstn) begin
        if (!rstn) begin
            state     <= LOC_IDLE;
            trig_done <= 1'b0;
        end else begin
            if (fire && local_task.is_read) begin
                state <= LOC_RD_BEAT;
            end else if (o_beat_valid && i_beat_ready) begin
                state <= LOC_IDLE;
            end
            // set has priority over a clear in the same cycle
            if (i_trig_set) begin
                trig_done <= 1'b1;
            end else if (trig_clear) begin
                trig_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (fire && local_task.is_read) begin
            o_beat_data <= addr_hit ? status_word : '0;
        end
    end

endmodule

`default_nettype wire

/* rd_return_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_return_unit
    import axi_pkg::*;
    import link_pkg::*;
(
    input  wire                SLAVE_CLK,
    input  wire                rstn,
    input  wire                i_fifo_wr,
    input  wire [DATA_W-1:0]   i_fifo_data,
    input  wire                i_fifo_last,
    input  wire                i_beat_valid,
    input  wire [DATA_W-1:0]   i_beat_data,
    output logic               o_beat_ready,
    output logic [DATA_W-1:0]  o_rdata,
    output logic [RESP_W-1:0]  o_rresp,
    output logic               o_rlast,
    output logic               o_rvalid,
    input  wire                i_rready,
    output logic               o_read_done
);

    // last flag stored above the data word
    logic [DATA_W:0]                mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH):0]    wr_ptr, rd_ptr;
    logic                           fifo_empty, slot_free, pop, beat_take;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign slot_free  = ~o_rvalid | i_rready;
    assign pop        = slot_free & ~fifo_empty;

    // only one read in flight, so the FIFO and the local beat never compete
    assign o_beat_ready = slot_free & fifo_empty;
    assign beat_take    = i_beat_valid & o_beat_ready;

    assign o_rresp     = RESP_OKAY;
    assign o_read_done = o_rvalid & i_rready & o_rlast;

    always_ff @(posedge SLAVE_CLK or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            o_rvalid <= 1'b0;
        end else begin
            if (i_fifo_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (slot_free) begin
                o_rvalid <= pop | beat_take;
            end
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (i_fifo_wr) begin
            mem[wr_ptr[$clog2(FIFO_DEPTH)-1:0]] <= {i_fifo_last, i_fifo_data};
        end
        if (pop) begin
            {o_rlast, o_rdata} <= mem[rd_ptr[$clog2(FIFO_DEPTH)-1:0]];
        end else if (beat_take) begin
            o_rlast <= 1'b1;
            o_rdata <= i_beat_data;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_link_bridge \
    -f sim.f -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 &&
! grep -q "Regression failed" sim.log &&
echo "run_sim: no failure found in sim.log" ||
{ echo "run_sim: failed, see build.log and sim.log"; exit 1; }

/* sim.f */
axi_pkg.sv
link_pkg.sv
task_if.sv
axi_slave_port.sv
link_tx_framer.sv
local_status_unit.sv
link_rx_parser.sv
rd_return_unit.sv
axi_link_bridge.sv
axi_link_bridge_sva.sv
tb_axi_link_bridge.sv

/* task_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one bus task handed from the slave port to a task unit
interface task_if
    import axi_pkg::*;
();

    logic              valid;
    logic              is_read;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [DATA_W-1:0] data;
    logic              ready;

    modport issuer (output valid, is_read, addr, len, data, input ready);

    modport target (input valid, is_read, addr, len, data, output ready);

endinterface

`default_nettype wire

/* tb_axi_link_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_link_bridge
    import axi_pkg::*;
    import link_pkg::*;
();

    localparam int TRACE_MAX = 32;
    localparam int FIELDS    = 6;

    // trace operation codes
    localparam logic [31:0] OP_IDLE  = 32'h0;
    localparam logic [31:0] OP_WRITE = 32'h1;
    localparam logic [31:0] OP_READ  = 32'h2;
    localparam logic [31:0] OP_BURST = 32'h3;
    localparam logic [31:0] OP_RXCMD = 32'h4;
    localparam logic [31:0] OP_END   = 32'hF;

    logic              SLAVE_CLK;
    logic              rstn;
    logic [ID_W-1:0]   i_awid;
    logic [ADDR_W-1:0] i_awaddr;
    logic [LEN_W-1:0]  i_awlen;
    logic              i_awvalid;
    logic              o_awready;
    logic [DATA_W-1:0] i_wdata;
    logic              i_wvalid;
    logic              o_wready;
    logic [ID_W-1:0]   o_bid;
    logic [RESP_W-1:0] o_bresp;
    logic              o_bvalid;
    logic              i_bready;
    logic [ID_W-1:0]   i_arid;
    logic [ADDR_W-1:0] i_araddr;
    logic [LEN_W-1:0]  i_arlen;
    logic              i_arvalid;
    logic              o_arready;
    logic [ID_W-1:0]   o_rid;
    logic [DATA_W-1:0] o_rdata;
    logic [RESP_W-1:0] o_rresp;
    logic              o_rlast;
    logic              o_rvalid;
    logic              i_rready;
    logic [DATA_W-1:0] i_rx_data;
    logic              i_rx_valid;
    logic              i_rx_last;
    logic [31:0]       o_tx_data;
    logic [K_W-1:0]    o_tx_k;

    logic [31:0]       trace_mem [TRACE_MAX*FIELDS];
    logic [31:0]       expect_q [$];
    logic [15:0]       lfsr_state;
    logic [ID_W-1:0]   pending_arid;
    int                cycle_count;
    int                cycle_limit;

    axi_link_bridge i_axi_link_bridge (.*);

    initial begin
        SLAVE_CLK = 1'b0;
        forever begin
            #20 SLAVE_CLK = ~SLAVE_CLK;
        end
    end

    // watchdog on the whole run
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge SLAVE_CLK);
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                $display("watchdog expired after %0d cycles, the DUT stopped responding",
                         cycle_count);
                abort_run();
            end
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic tick();
        @(negedge SLAVE_CLK);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic take_rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return b;
    endfunction

    task automatic check_link_idle();
        check_eq("o_tx_data", o_tx_data, IDLE_WORD);
        check_eq("o_tx_k", 32'(o_tx_k), 32'hF);
    endtask

    task automatic check_idle();
        check_eq("o_awready", 32'(o_awready), 32'h1);
        check_eq("o_wready", 32'(o_wready), 32'h1);
        check_eq("o_arready", 32'(o_arready), 32'h1);
        check_eq("o_bvalid", 32'(o_bvalid), 32'h0);
        check_eq("o_rvalid", 32'(o_rvalid), 32'h0);
        check_link_idle();
    endtask

    // ready is registered, so the value seen now is the one the next edge uses
    task automatic send_write(input logic [ID_W-1:0] id, input logic [31:0] addr,
                              input logic [31:0] data);
        logic aw_seen;
        logic w_seen;
        i_awid    = id;
        i_awaddr  = addr;
        i_awlen   = '0;
        i_awvalid = 1'b1;
        i_wdata   = data;
        i_wvalid  = 1'b1;
        while (i_awvalid || i_wvalid) begin
            aw_seen = o_awready;
            w_seen  = o_wready;
            tick();
            if (aw_seen) begin
                i_awvalid = 1'b0;
            end
            if (w_seen) begin
                i_wvalid = 1'b0;
            end
        end
    endtask

    task automatic send_read(input logic [ID_W-1:0] id, input logic [31:0] addr,
                             input logic [LEN_W-1:0] len);
        logic ar_seen;
        i_arid    = id;
        i_araddr  = addr;
        i_arlen   = len;
        i_arvalid = 1'b1;
        while (i_arvalid) begin
            ar_seen = o_arready;
            tick();
            if (ar_seen) begin
                i_arvalid = 1'b0;
            end
        end
    endtask

    // header then command word on back to back cycles, then idle again
    task automatic check_frame(input logic [31:0] head, input logic [31:0] cmd);
        while (o_tx_k == '1) begin
            tick();
        end
        check_eq("o_tx_data header", o_tx_data, head);
        tick();
        check_eq("o_tx_data command", o_tx_data, cmd);
        check_eq("o_tx_k command", 32'(o_tx_k), 32'h0);
        tick();
        check_link_idle();
    endtask

    task automatic collect_b(input logic [ID_W-1:0] id);
        logic            taken;
        logic            seen;
        logic [ID_W-1:0] bid_s;
        logic [1:0]      bresp_s;
        taken = 1'b0;
        while (!taken) begin
            i_bready = take_rand_bit();
            seen     = o_bvalid;
            bid_s    = o_bid;
            bresp_s  = o_bresp;
            tick();
            if (seen && i_bready) begin
                taken = 1'b1;
                check_eq("o_bid", 32'(bid_s), 32'(id));
                check_eq("o_bresp", 32'(bresp_s), 32'(RESP_OKAY));
            end
        end
        i_bready = 1'b0;
    endtask

    task automatic collect_r(input logic [ID_W-1:0] id);
        logic            seen;
        logic            last_s;
        logic [31:0]     data_s;
        logic [ID_W-1:0] rid_s;
        logic [1:0]      rresp_s;
        logic [31:0]     exp_word;
        while (expect_q.size() > 0) begin
            i_rready = take_rand_bit();
            seen     = o_rvalid;
            data_s   = o_rdata;
            last_s   = o_rlast;
            rid_s    = o_rid;
            rresp_s  = o_rresp;
            tick();
            if (seen && i_rready) begin
                exp_word = expect_q.pop_front();
                check_eq("o_rdata", data_s, exp_word);
                check_eq("o_rlast", 32'(last_s), 32'(expect_q.size() == 0));
                check_eq("o_rid", 32'(rid_s), 32'(id));
                check_eq("o_rresp", 32'(rresp_s), 32'(RESP_OKAY));
            end
        end
        i_rready = 1'b0;
        tick();
        // address channel open again before the next read
        check_eq("o_arready", 32'(o_arready), 32'h1);
    endtask

    task automatic send_rx_word(input logic [31:0] data, input logic last);
        i_rx_valid = 1'b1;
        i_rx_data  = data;
        i_rx_last  = last;
        tick();
        i_rx_valid = 1'b0;
        i_rx_last  = 1'b0;
    endtask

    initial begin
        logic [31:0] fld [FIELDS];
        int          n_ops;
        rstn       = 1'b0;
        i_awid     = '0;
        i_awaddr   = '0;
        i_awlen    = '0;
        i_awvalid  = 1'b0;
        i_wdata    = '0;
        i_wvalid   = 1'b0;
        i_bready   = 1'b0;
        i_arid     = '0;
        i_araddr   = '0;
        i_arlen    = '0;
        i_arvalid  = 1'b0;
        i_rready   = 1'b0;
        i_rx_data  = '0;
        i_rx_valid = 1'b0;
        i_rx_last  = 1'b0;
        lfsr_state = 16'd30;
        $readmemh("bridge_trace.txt", trace_mem);
        n_ops = 0;
        while (n_ops < TRACE_MAX && trace_mem[n_ops*FIELDS] !== OP_END) begin
            n_ops = n_ops + 1;
        end
        cycle_limit = 40 + n_ops * 100;
        repeat (10) tick();
        rstn = 1'b1;
        tick();
        for (int i = 0; i < n_ops; i++) begin
            for (int f = 0; f < FIELDS; f++) begin
                fld[f] = trace_mem[i*FIELDS + f];
            end
            case (fld[0])
                OP_IDLE: check_idle();
                OP_WRITE: begin
                    send_write(fld[1][ID_W-1:0], fld[2], fld[3]);
                    if (fld[2][REMOTE_BIT]) begin
                        check_frame({WR_HEAD_BYTE, 24'h00_0000}, fld[4]);
                    end
                    collect_b(fld[1][ID_W-1:0]);
                end
                OP_READ: begin
                    send_read(fld[1][ID_W-1:0], fld[2], fld[3][LEN_W-1:0]);
                    if (fld[2][REMOTE_BIT]) begin
                        check_frame({RD_HEAD_BYTE, 24'h00_0000}, fld[4]);
                        pending_arid = fld[1][ID_W-1:0];
                    end else begin
                        expect_q.push_back(fld[4]);
                        collect_r(fld[1][ID_W-1:0]);
                    end
                end
                OP_BURST: begin
                    send_rx_word({RD_HEAD_BYTE, 24'h00_0000}, 1'b0);
                    for (int k = 0; k < int'(fld[1]) && k < FIELDS - 2; k++) begin
                        expect_q.push_back(fld[k+2]);
                        send_rx_word(fld[k+2], k == int'(fld[1]) - 1);
                    end
                    collect_r(pending_arid);
                end
                OP_RXCMD: begin
                    send_rx_word({WR_HEAD_BYTE, 24'h00_0000}, 1'b0);
                    send_rx_word(fld[1], 1'b0);
                end
                default: begin
                    $display("trace line %0d holds an unknown operation code %h", i, fld[0]);
                    abort_run();
                end
            endcase
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
